// File: rtl/uc_pkg.sv
package uc_pkg;

  localparam int paddr_width_gp = 32;
  localparam int dword_width_gp = 64;
  localparam int src_width_gp   = 1;
  localparam int num_dev_gp     = 3;
  localparam int core_id_width_gp = 8;

  localparam logic [paddr_width_gp-1:0] dram_base_gp = 32'h8000_0000;

  // Local device field of a physical address
  localparam int dev_msb_gp = 23;
  localparam int dev_lsb_gp = 20;

  localparam logic [dev_msb_gp-dev_lsb_gp:0] cfg_dev_id_gp   = 'd2;
  localparam logic [dev_msb_gp-dev_lsb_gp:0] clint_dev_id_gp = 'd1;

  // Offsets inside a device, taken from the bits below the device field
  localparam logic [dev_lsb_gp-1:0] cfg_freeze_ofs_gp  = 'h0;
  localparam logic [dev_lsb_gp-1:0] cfg_core_id_ofs_gp = 'h8;
  localparam logic [dev_lsb_gp-1:0] cfg_did_ofs_gp     = 'h10;

  localparam logic [dev_lsb_gp-1:0] clint_msip_ofs_gp     = 'h0;
  localparam logic [dev_lsb_gp-1:0] clint_mtimecmp_ofs_gp = 'h4000;
  localparam logic [dev_lsb_gp-1:0] clint_mtime_ofs_gp    = 'hBFF8;
  localparam logic [dev_lsb_gp-1:0] clint_meip_ofs_gp     = 'hC000;

  typedef enum logic
  {
    op_read  = 1'b0,
    op_write = 1'b1
  } uc_opcode_e;

  typedef enum logic [1:0]
  {
    dev_cfg   = 2'd0,
    dev_clint = 2'd1,
    dev_mem   = 2'd2
  } uc_dev_e;

  // One beat, used for both commands and responses
  typedef struct packed
  {
    uc_opcode_e                 opcode;
    logic [paddr_width_gp-1:0] addr;
    logic [src_width_gp-1:0]   src;
    logic [dword_width_gp-1:0] data;
  } uc_msg_s;

endpackage

// File: rtl/uc_cmd_decode.sv
`timescale 1ns/1ps

module uc_cmd_decode
  (
    input  logic [uc_pkg::paddr_width_gp-1:0] addr_i,
    output uc_pkg::uc_dev_e                   dst_o
  );

  logic                                             local_cmd;
  logic [uc_pkg::dev_msb_gp-uc_pkg::dev_lsb_gp:0]   dev_code;

  // Anything under the DRAM base is a local device space
  assign local_cmd = (addr_i < uc_pkg::dram_base_gp);
  assign dev_code  = addr_i[uc_pkg::dev_msb_gp:uc_pkg::dev_lsb_gp];

  always_comb
  begin
    dst_o = uc_pkg::dev_mem;
    if (local_cmd)
    begin
      if (dev_code == uc_pkg::cfg_dev_id_gp)
      begin
        dst_o = uc_pkg::dev_cfg;
      end
      else if (dev_code == uc_pkg::clint_dev_id_gp)
      begin
        dst_o = uc_pkg::dev_clint;
      end
      // unmapped local codes fall through to memory
    end
  end

endmodule

// File: rtl/uc_xbar.sv
`timescale 1ns/1ps

module uc_xbar
  #(
    parameter int num_src_p = 2,
    parameter int num_dst_p = 3,
    parameter int lg_src_lp = (num_src_p > 1) ? $clog2(num_src_p) : 1,
    parameter int lg_dst_lp = (num_dst_p > 1) ? $clog2(num_dst_p) : 1
  )
  (
    input  logic                                 clk_i,
    input  logic                                 rst_i,

    input  uc_pkg::uc_msg_s [num_src_p-1:0]      src_msg_i,
    input  logic [num_src_p-1:0]                 src_v_i,
    input  logic [num_src_p-1:0][lg_dst_lp-1:0]  src_dst_i,
    output logic [num_src_p-1:0]                 src_ready_o,

    output uc_pkg::uc_msg_s [num_dst_p-1:0]      dst_msg_o,
    output logic [num_dst_p-1:0]                 dst_v_o,
    input  logic [num_dst_p-1:0]                 dst_ready_i
  );

  logic [num_dst_p-1:0][num_src_p-1:0] grant_all;

  for (genvar j = 0; j < num_dst_p; j++)
  begin : sink
    logic [num_src_p-1:0] req;
    logic [num_src_p-1:0] grant;
    logic [lg_src_lp-1:0] ptr_r;
    logic [lg_src_lp-1:0] win;
    logic                 found;

    for (genvar i = 0; i < num_src_p; i++)
    begin : req_bit
      assign req[i] = src_v_i[i] & (src_dst_i[i] == lg_dst_lp'(j));
    end

    // Search upward from the pointer, wrapping at the last source
    always_comb
    begin
      int idx;
      grant = '0;
      win   = ptr_r;
      found = 1'b0;
      for (int k = 0; k < num_src_p; k++)
      begin
        idx = int'(ptr_r) + k;
        if (idx >= num_src_p)
        begin
          idx = idx - num_src_p;
        end
        if (!found && req[idx])
        begin
          found      = 1'b1;
          win        = lg_src_lp'(idx);
          grant[idx] = 1'b1;
        end
      end
    end

    assign grant_all[j] = grant;
    assign dst_v_o[j]   = found;
    assign dst_msg_o[j] = src_msg_i[win];

    // Pointer only moves on a completed transfer
    always_ff @(posedge clk_i)
    begin
      if (rst_i)
      begin
        ptr_r <= '0;
      end
      else if (dst_v_o[j] && dst_ready_i[j])
      begin
        ptr_r <= (win == lg_src_lp'(num_src_p-1)) ? '0 : win + 1'b1;
      end
    end

    grant_onehot_a: assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(grant))
      else $error("uc_xbar: sink %0d granted more than one source", j);
  end

  // Each source targets one sink, so at most one term is set
  always_comb
  begin
    src_ready_o = '0;
    for (int j = 0; j < num_dst_p; j++)
    begin
      src_ready_o = src_ready_o | (grant_all[j] & {num_src_p{dst_ready_i[j]}});
    end
  end

endmodule

// File: rtl/uc_cfg_slice.sv
`timescale 1ns/1ps

module uc_cfg_slice
  #(
    parameter int did_width_p = 8
  )
  (
    input  logic                                 clk_i,
    input  logic                                 rst_i,
    input  logic [did_width_p-1:0]               did_i,

    input  uc_pkg::uc_msg_s                      cmd_msg_i,
    input  logic                                 cmd_v_i,
    output logic                                 cmd_ready_o,

    output uc_pkg::uc_msg_s                      resp_msg_o,
    output logic                                 resp_v_o,
    input  logic                                 resp_ready_i,

    output logic                                 freeze_o,
    output logic [uc_pkg::core_id_width_gp-1:0]  core_id_o
  );

  uc_pkg::uc_msg_s                       resp_r;
  logic                                  resp_v_r;
  logic                                  cmd_fire;
  logic                                  is_write;
  logic [uc_pkg::dev_lsb_gp-1:0]         ofs;
  logic [uc_pkg::dword_width_gp-1:0]     rdata;
  logic                                  freeze_r;
  logic [uc_pkg::core_id_width_gp-1:0]   core_id_r;

  // Accept when the response slot is free or emptying now
  assign cmd_ready_o = ~resp_v_r | resp_ready_i;
  assign cmd_fire    = cmd_v_i & cmd_ready_o;
  assign is_write    = (cmd_msg_i.opcode == uc_pkg::op_write);
  assign ofs         = cmd_msg_i.addr[uc_pkg::dev_lsb_gp-1:0];

  always_comb
  begin
    rdata = '0;
    if (!is_write)
    begin
      case (ofs)
        uc_pkg::cfg_freeze_ofs_gp:
          rdata = {{(uc_pkg::dword_width_gp-1){1'b0}}, freeze_r};
        uc_pkg::cfg_core_id_ofs_gp:
          rdata = {{(uc_pkg::dword_width_gp-uc_pkg::core_id_width_gp){1'b0}}, core_id_r};
        uc_pkg::cfg_did_ofs_gp:
          rdata = {{(uc_pkg::dword_width_gp-did_width_p){1'b0}}, did_i};
        default:
          rdata = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      freeze_r  <= 1'b1;
      core_id_r <= '0;
    end
    else if (cmd_fire && is_write)
    begin
      if (ofs == uc_pkg::cfg_freeze_ofs_gp)
      begin
        freeze_r <= cmd_msg_i.data[0];
      end
      if (ofs == uc_pkg::cfg_core_id_ofs_gp)
      begin
        core_id_r <= cmd_msg_i.data[uc_pkg::core_id_width_gp-1:0];
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      resp_v_r <= 1'b0;
    end
    else if (cmd_fire)
    begin
      resp_v_r <= 1'b1;
    end
    else if (resp_ready_i)
    begin
      resp_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
    begin
      resp_r.opcode <= cmd_msg_i.opcode;
      resp_r.addr   <= cmd_msg_i.addr;
      resp_r.src    <= cmd_msg_i.src;
      resp_r.data   <= rdata;
    end
  end

  assign resp_msg_o = resp_r;
  assign resp_v_o   = resp_v_r;
  assign freeze_o   = freeze_r;
  assign core_id_o  = core_id_r;

  resp_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
    resp_v_o && !resp_ready_i |=> resp_v_o && $stable(resp_msg_o))
    else $error("uc_cfg_slice: stalled response changed");

endmodule

// File: rtl/uc_clint_slice.sv
`timescale 1ns/1ps

module uc_clint_slice
  (
    input  logic             clk_i,
    input  logic             rt_clk_i,
    input  logic             rst_i,

    input  uc_pkg::uc_msg_s  cmd_msg_i,
    input  logic             cmd_v_i,
    output logic             cmd_ready_o,

    output uc_pkg::uc_msg_s  resp_msg_o,
    output logic             resp_v_o,
    input  logic             resp_ready_i,

    output logic             timer_irq_o,
    output logic             software_irq_o,
    output logic             external_irq_o
  );

  uc_pkg::uc_msg_s                    resp_r;
  logic                               resp_v_r;
  logic                               cmd_fire;
  logic                               is_write;
  logic [uc_pkg::dev_lsb_gp-1:0]      ofs;
  logic [uc_pkg::dword_width_gp-1:0]  rdata;
  logic [2:0]                         rt_sync_r;
  logic                               rt_tick;
  logic [uc_pkg::dword_width_gp-1:0]  mtime_r;
  logic [uc_pkg::dword_width_gp-1:0]  mtimecmp_r;
  logic                               msip_r;
  logic                               meip_r;
  logic                               mtime_wr;

  assign cmd_ready_o = ~resp_v_r | resp_ready_i;
  assign cmd_fire    = cmd_v_i & cmd_ready_o;
  assign is_write    = (cmd_msg_i.opcode == uc_pkg::op_write);
  assign ofs         = cmd_msg_i.addr[uc_pkg::dev_lsb_gp-1:0];
  assign mtime_wr    = cmd_fire & is_write & (ofs == uc_pkg::clint_mtime_ofs_gp);

  // Two stages to synchronize, the third detects the rising edge
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      rt_sync_r <= '0;
    end
    else
    begin
      rt_sync_r <= {rt_sync_r[1:0], rt_clk_i};
    end
  end

  assign rt_tick = rt_sync_r[1] & ~rt_sync_r[2];

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      mtime_r    <= '0;
      mtimecmp_r <= '1;
      msip_r     <= 1'b0;
      meip_r     <= 1'b0;
    end
    else
    begin
      if (mtime_wr)
      begin
        mtime_r <= cmd_msg_i.data;
      end
      else if (rt_tick)
      begin
        mtime_r <= mtime_r + 1'b1;
      end
      if (cmd_fire && is_write)
      begin
        case (ofs)
          uc_pkg::clint_msip_ofs_gp:     msip_r     <= cmd_msg_i.data[0];
          uc_pkg::clint_mtimecmp_ofs_gp: mtimecmp_r <= cmd_msg_i.data;
          uc_pkg::clint_meip_ofs_gp:     meip_r     <= cmd_msg_i.data[0];
          default:                       msip_r     <= msip_r;
        endcase
      end
    end
  end

  always_comb
  begin
    rdata = '0;
    if (!is_write)
    begin
      case (ofs)
        uc_pkg::clint_msip_ofs_gp:
          rdata = {{(uc_pkg::dword_width_gp-1){1'b0}}, msip_r};
        uc_pkg::clint_mtimecmp_ofs_gp:
          rdata = mtimecmp_r;
        uc_pkg::clint_mtime_ofs_gp:
          rdata = mtime_r;
        uc_pkg::clint_meip_ofs_gp:
          rdata = {{(uc_pkg::dword_width_gp-1){1'b0}}, meip_r};
        default:
          rdata = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      resp_v_r <= 1'b0;
    end
    else if (cmd_fire)
    begin
      resp_v_r <= 1'b1;
    end
    else if (resp_ready_i)
    begin
      resp_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
    begin
      resp_r.opcode <= cmd_msg_i.opcode;
      resp_r.addr   <= cmd_msg_i.addr;
      resp_r.src    <= cmd_msg_i.src;
      resp_r.data   <= rdata;
    end
  end

  assign resp_msg_o     = resp_r;
  assign resp_v_o       = resp_v_r;
  assign timer_irq_o    = (mtime_r >= mtimecmp_r);
  assign software_irq_o = msip_r;
  assign external_irq_o = meip_r;

  // Only a software write may move mtime backwards
  mtime_mono_a: assert property (@(posedge clk_i) disable iff (rst_i)
    !mtime_wr |=> mtime_r >= $past(mtime_r))
    else $error("uc_clint_slice: mtime went backwards");

endmodule

// File: rtl/uc_fabric.sv
`timescale 1ns/1ps

module uc_fabric
  #(
    parameter int did_width_p = 8
  )
  (
    input  logic                                 clk_i,
    input  logic                                 rt_clk_i,
    input  logic                                 rst_i,
    input  logic [did_width_p-1:0]               my_did_i,

    input  uc_pkg::uc_msg_s [1:0]                req_cmd_msg_i,
    input  logic [1:0]                           req_cmd_v_i,
    output logic [1:0]                           req_cmd_ready_o,

    output uc_pkg::uc_msg_s [1:0]                req_resp_msg_o,
    output logic [1:0]                           req_resp_v_o,
    input  logic [1:0]                           req_resp_ready_i,

    output uc_pkg::uc_msg_s                      mem_cmd_msg_o,
    output logic                                 mem_cmd_v_o,
    input  logic                                 mem_cmd_ready_i,

    input  uc_pkg::uc_msg_s                      mem_resp_msg_i,
    input  logic                                 mem_resp_v_i,
    output logic                                 mem_resp_ready_o,

    output logic                                 freeze_o,
    output logic [uc_pkg::core_id_width_gp-1:0]  core_id_o,
    output logic                                 timer_irq_o,
    output logic                                 software_irq_o,
    output logic                                 external_irq_o
  );

  // Device slots follow uc_dev_e
  uc_pkg::uc_msg_s [uc_pkg::num_dev_gp-1:0]     dev_cmd_msg;
  logic [uc_pkg::num_dev_gp-1:0]                dev_cmd_v;
  logic [uc_pkg::num_dev_gp-1:0]                dev_cmd_ready;
  uc_pkg::uc_msg_s [uc_pkg::num_dev_gp-1:0]     dev_resp_msg;
  logic [uc_pkg::num_dev_gp-1:0]                dev_resp_v;
  logic [uc_pkg::num_dev_gp-1:0]                dev_resp_ready;
  logic [1:0][1:0]                              req_cmd_dst;
  logic [uc_pkg::num_dev_gp-1:0][uc_pkg::src_width_gp-1:0] dev_resp_dst;

  for (genvar p = 0; p < 2; p++)
  begin : port
    uc_cmd_decode decode
      (
        .addr_i (req_cmd_msg_i[p].addr),
        .dst_o  (req_cmd_dst[p])
      );
  end

  // Responses go home by the requester index they carry
  for (genvar d = 0; d < uc_pkg::num_dev_gp; d++)
  begin : resp_route
    assign dev_resp_dst[d] = dev_resp_msg[d].src;
  end

  uc_xbar #(.num_src_p(2), .num_dst_p(uc_pkg::num_dev_gp)) cmd_xbar
    (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .src_msg_i   (req_cmd_msg_i),
      .src_v_i     (req_cmd_v_i),
      .src_dst_i   (req_cmd_dst),
      .src_ready_o (req_cmd_ready_o),
      .dst_msg_o   (dev_cmd_msg),
      .dst_v_o     (dev_cmd_v),
      .dst_ready_i (dev_cmd_ready)
    );

  uc_xbar #(.num_src_p(uc_pkg::num_dev_gp), .num_dst_p(2)) resp_xbar
    (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .src_msg_i   (dev_resp_msg),
      .src_v_i     (dev_resp_v),
      .src_dst_i   (dev_resp_dst),
      .src_ready_o (dev_resp_ready),
      .dst_msg_o   (req_resp_msg_o),
      .dst_v_o     (req_resp_v_o),
      .dst_ready_i (req_resp_ready_i)
    );

  uc_cfg_slice #(.did_width_p(did_width_p)) cfg
    (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .did_i        (my_did_i),
      .cmd_msg_i    (dev_cmd_msg[uc_pkg::dev_cfg]),
      .cmd_v_i      (dev_cmd_v[uc_pkg::dev_cfg]),
      .cmd_ready_o  (dev_cmd_ready[uc_pkg::dev_cfg]),
      .resp_msg_o   (dev_resp_msg[uc_pkg::dev_cfg]),
      .resp_v_o     (dev_resp_v[uc_pkg::dev_cfg]),
      .resp_ready_i (dev_resp_ready[uc_pkg::dev_cfg]),
      .freeze_o     (freeze_o),
      .core_id_o    (core_id_o)
    );

  uc_clint_slice clint
    (
      .clk_i          (clk_i),
      .rt_clk_i       (rt_clk_i),
      .rst_i          (rst_i),
      .cmd_msg_i      (dev_cmd_msg[uc_pkg::dev_clint]),
      .cmd_v_i        (dev_cmd_v[uc_pkg::dev_clint]),
      .cmd_ready_o    (dev_cmd_ready[uc_pkg::dev_clint]),
      .resp_msg_o     (dev_resp_msg[uc_pkg::dev_clint]),
      .resp_v_o       (dev_resp_v[uc_pkg::dev_clint]),
      .resp_ready_i   (dev_resp_ready[uc_pkg::dev_clint]),
      .timer_irq_o    (timer_irq_o),
      .software_irq_o (software_irq_o),
      .external_irq_o (external_irq_o)
    );

  // External memory sits in the last device slot
  assign mem_cmd_msg_o                   = dev_cmd_msg[uc_pkg::dev_mem];
  assign mem_cmd_v_o                     = dev_cmd_v[uc_pkg::dev_mem];
  assign dev_cmd_ready[uc_pkg::dev_mem]  = mem_cmd_ready_i;
  assign dev_resp_msg[uc_pkg::dev_mem]   = mem_resp_msg_i;
  assign dev_resp_v[uc_pkg::dev_mem]     = mem_resp_v_i;
  assign mem_resp_ready_o                = dev_resp_ready[uc_pkg::dev_mem];

endmodule

// File: include/uc_tb_tests.svh
`ifndef UC_TB_TESTS_SVH
`define UC_TB_TESTS_SVH

localparam logic [31:0] cfg_base_c      = 32'h0020_0000;
localparam logic [31:0] clint_base_c    = 32'h0010_0000;
localparam logic [31:0] dram_addr_c     = 32'h8000_1230;
// Local space with device code 5, which nothing claims
localparam logic [31:0] unmapped_addr_c = 32'h0050_0040;

task automatic test_cfg_regs();
  int          err0;
  int          lat;
  logic [63:0] rd;
  logic [7:0]  id;
  err0 = errors;
  id   = 8'($urandom);
  check_value("freeze_o", freeze, 1);
  check_value("req_resp_v_o", req_resp_v, 0);
  check_value("mem_cmd_v_o", mem_cmd_v, 0);
  access(0, uc_pkg::op_read, cfg_base_c + 32'h10, 64'h0, 1'b1, rd, lat);
  check_value("did read data", rd, {56'h0, my_did});
  check_value("cfg response latency", lat, 1);
  access(1, uc_pkg::op_write, cfg_base_c, 64'h0, 1'b1, rd, lat);
  check_value("freeze_o", freeze, 0);
  check_value("cfg write response data", rd, 0);
  check_value("cfg response latency", lat, 1);
  access(0, uc_pkg::op_write, cfg_base_c + 32'h8, {56'h0, id}, 1'b1, rd, lat);
  check_value("core_id_o", core_id, id);
  access(1, uc_pkg::op_read, cfg_base_c, 64'h0, 1'b1, rd, lat);
  check_value("freeze read data", rd, 0);
  access(0, uc_pkg::op_read, cfg_base_c + 32'h8, 64'h0, 1'b1, rd, lat);
  check_value("core_id read data", rd, {56'h0, id});
  check_value("cfg response latency", lat, 1);
  finish_test("cfg_regs", err0);
endtask

task automatic test_timer();
  int          err0;
  int          lat;
  int          n;
  logic [63:0] rd;
  logic [63:0] t0;
  logic [63:0] t1;
  err0 = errors;
  access(0, uc_pkg::op_read, clint_base_c + 32'h4000, 64'h0, 1'b1, rd, lat);
  check_value("mtimecmp after reset", rd, 64'hffff_ffff_ffff_ffff);
  check_value("timer_irq_o", timer_irq, 0);
  access(0, uc_pkg::op_read, clint_base_c + 32'hbff8, 64'h0, 1'b1, t0, lat);
  idle(30);
  access(1, uc_pkg::op_read, clint_base_c + 32'hbff8, 64'h0, 1'b1, t1, lat);
  check_true(t1 > t0, $sformatf("mtime did not advance, read 'h%0h then 'h%0h", t0, t1));
  access(0, uc_pkg::op_write, clint_base_c + 32'h4000, t1 + 64'd3, 1'b1, rd, lat);
  check_value("timer_irq_o", timer_irq, 0);
  n = 0;
  while (!timer_irq && n < 6 * rt_cycles_c)
  begin
    idle(1);
    n++;
  end
  check_true(timer_irq, "timer_irq_o did not rise within 6 rt_clk periods");
  access(1, uc_pkg::op_write, clint_base_c + 32'h4000, 64'hffff_ffff_ffff_ffff,
         1'b1, rd, lat);
  check_value("timer_irq_o", timer_irq, 0);
  finish_test("timer", err0);
endtask

task automatic test_soft_ext_irq();
  int          err0;
  int          lat;
  logic [63:0] rd;
  err0 = errors;
  access(0, uc_pkg::op_write, clint_base_c, 64'h1, 1'b1, rd, lat);
  check_value("software_irq_o", software_irq, 1);
  check_value("external_irq_o", external_irq, 0);
  access(1, uc_pkg::op_read, clint_base_c, 64'h0, 1'b1, rd, lat);
  check_value("msip read data", rd, 1);
  access(1, uc_pkg::op_write, clint_base_c, 64'h0, 1'b1, rd, lat);
  check_value("software_irq_o", software_irq, 0);
  access(0, uc_pkg::op_write, clint_base_c + 32'hc000, 64'h1, 1'b1, rd, lat);
  check_value("external_irq_o", external_irq, 1);
  check_value("software_irq_o", software_irq, 0);
  access(0, uc_pkg::op_read, clint_base_c + 32'hc000, 64'h0, 1'b1, rd, lat);
  check_value("meip read data", rd, 1);
  access(1, uc_pkg::op_write, clint_base_c + 32'hc000, 64'h0, 1'b1, rd, lat);
  check_value("external_irq_o", external_irq, 0);
  finish_test("soft_ext_irq", err0);
endtask

task automatic test_mem_routing();
  int          err0;
  int          lat;
  int          n;
  bit          got;
  logic [63:0] rd;
  logic [63:0] wd;
  err0 = errors;
  wd   = {$urandom, $urandom};
  access(0, uc_pkg::op_write, dram_addr_c, wd, 1'b1, rd, lat);
  check_value("mem_cmd_msg_o", mem_last_cmd, make_msg(uc_pkg::op_write, dram_addr_c, 0, wd));
  check_value("memory write response data", rd, 0);
  access(1, uc_pkg::op_read, dram_addr_c, 64'h0, 1'b1, rd, lat);
  check_value("mem_cmd_msg_o", mem_last_cmd, make_msg(uc_pkg::op_read, dram_addr_c, 1, 64'h0));
  check_value("memory read data", rd, {32'h0, dram_addr_c} ^ mem_xor_c);
  access(0, uc_pkg::op_read, unmapped_addr_c, 64'h0, 1'b1, rd, lat);
  check_value("mem_cmd_msg_o", mem_last_cmd,
              make_msg(uc_pkg::op_read, unmapped_addr_c, 0, 64'h0));
  check_value("memory read data", rd, {32'h0, unmapped_addr_c} ^ mem_xor_c);
  wd = {$urandom, $urandom};
  access(1, uc_pkg::op_write, unmapped_addr_c, wd, 1'b1, rd, lat);
  check_value("mem_cmd_msg_o", mem_last_cmd,
              make_msg(uc_pkg::op_write, unmapped_addr_c, 1, wd));

  // A stalled port holds off the memory response
  req_resp_ready[1] = 1'b0;
  send_cmd(1, make_msg(uc_pkg::op_read, dram_addr_c, 1, 64'h0));
  n   = 0;
  got = 1'b0;
  while (!got && n < wait_limit_c)
  begin
    @(negedge clk);
    got = mem_resp_v;
    n++;
    @(posedge clk);
    #2;
  end
  check_true(got, "memory model never answered the stalled read");
  repeat (2)
  begin
    @(negedge clk);
    check_value("req_resp_v_o[1]", req_resp_v[1], 1);
    check_value("mem_resp_ready_o", mem_resp_ready, 0);
    @(posedge clk);
    #2;
  end
  req_resp_ready[1] = 1'b1;
  @(negedge clk);
  check_value("mem_resp_ready_o", mem_resp_ready, 1);
  check_value("req_resp_msg_o[1].data", req_resp_msg[1].data,
              {32'h0, dram_addr_c} ^ mem_xor_c);
  @(posedge clk);
  #2;
  finish_test("mem_routing", err0);
endtask

task automatic test_contention();
  int              err0;
  int              n;
  int              l0;
  int              l1;
  logic [63:0]     d0;
  logic [63:0]     d1;
  uc_pkg::uc_msg_s held;
  uc_pkg::uc_msg_s resp;
  err0 = errors;
  // Same-cycle cfg reads from both ports
  fork
    access(0, uc_pkg::op_read, cfg_base_c + 32'h10, 64'h0, 1'b0, d0, l0);
    access(1, uc_pkg::op_read, cfg_base_c, 64'h0, 1'b0, d1, l1);
  join
  check_value("port 0 did read data", d0, {56'h0, my_did});
  // Freeze still holds the zero written in the cfg test
  check_value("port 1 freeze read data", d1, 0);

  req_resp_ready[0] = 1'b0;
  send_cmd(0, make_msg(uc_pkg::op_read, cfg_base_c + 32'h10, 0, 64'h0));
  n = 0;
  while (!req_resp_v[0] && n < wait_limit_c)
  begin
    idle(1);
    n++;
  end
  check_true(req_resp_v[0], "stalled response never became valid on port 0");
  held = req_resp_msg[0];
  req_cmd_msg[1] = make_msg(uc_pkg::op_read, cfg_base_c, 1, 64'h0);
  req_cmd_v[1]   = 1'b1;
  repeat (4)
  begin
    @(negedge clk);
    check_value("req_resp_v_o[0]", req_resp_v[0], 1);
    check_value("req_resp_msg_o[0]", req_resp_msg[0], held);
    check_value("req_cmd_ready_o[1]", req_cmd_ready[1], 0);
    @(posedge clk);
    #2;
  end
  req_resp_ready[0] = 1'b1;
  @(negedge clk);
  check_value("req_resp_msg_o[0]", req_resp_msg[0], held);
  check_value("req_cmd_ready_o[1]", req_cmd_ready[1], 1);
  @(posedge clk);
  #2;
  req_cmd_v[1] = 1'b0;
  check_value("held response src", held.src, 0);
  check_value("held response data", held.data, {56'h0, my_did});
  wait_resp(1, 1'b0, resp, l1);
  check_value("port 1 freeze read data", resp.data, 0);
  check_value("req_resp_msg_o[1].src", resp.src, 1);
  check_value("cfg response latency", l1, 1);
  finish_test("contention", err0);
endtask

`endif

// File: verif/uc_fabric_tb.sv
`timescale 1ns/1ps

module uc_fabric_tb;

  localparam int clk_period_c      = 40;
  localparam int rt_half_c         = 200;
  localparam int rt_cycles_c       = 2 * rt_half_c / clk_period_c;
  localparam int num_tests_c       = 5;
  localparam int cycles_per_test_c = 200;
  localparam int wait_limit_c      = 50;
  localparam logic [63:0] mem_xor_c = 64'h5a5a_c3c3_0f0f_a5a5;

  logic                                 clk = 1'b0;
  logic                                 rt_clk = 1'b0;
  logic                                 rst;
  logic [7:0]                           my_did;
  uc_pkg::uc_msg_s [1:0]                req_cmd_msg;
  logic [1:0]                           req_cmd_v;
  logic [1:0]                           req_cmd_ready;
  uc_pkg::uc_msg_s [1:0]                req_resp_msg;
  logic [1:0]                           req_resp_v;
  logic [1:0]                           req_resp_ready;
  uc_pkg::uc_msg_s                      mem_cmd_msg;
  logic                                 mem_cmd_v;
  logic                                 mem_cmd_ready;
  uc_pkg::uc_msg_s                      mem_resp_msg;
  logic                                 mem_resp_v;
  logic                                 mem_resp_ready;
  logic                                 freeze;
  logic [uc_pkg::core_id_width_gp-1:0]  core_id;
  logic                                 timer_irq;
  logic                                 software_irq;
  logic                                 external_irq;

  int               errors;
  int               checks;
  int               tests_run;
  int               tests_failed;
  int               mem_delay [16];
  int               mem_count;
  logic             mem_fired;
  uc_pkg::uc_msg_s  mem_last_cmd;

  uc_fabric #(.did_width_p(8)) dut0
    (
      .clk_i            (clk),
      .rt_clk_i         (rt_clk),
      .rst_i            (rst),
      .my_did_i         (my_did),
      .req_cmd_msg_i    (req_cmd_msg),
      .req_cmd_v_i      (req_cmd_v),
      .req_cmd_ready_o  (req_cmd_ready),
      .req_resp_msg_o   (req_resp_msg),
      .req_resp_v_o     (req_resp_v),
      .req_resp_ready_i (req_resp_ready),
      .mem_cmd_msg_o    (mem_cmd_msg),
      .mem_cmd_v_o      (mem_cmd_v),
      .mem_cmd_ready_i  (mem_cmd_ready),
      .mem_resp_msg_i   (mem_resp_msg),
      .mem_resp_v_i     (mem_resp_v),
      .mem_resp_ready_o (mem_resp_ready),
      .freeze_o         (freeze),
      .core_id_o        (core_id),
      .timer_irq_o      (timer_irq),
      .software_irq_o   (software_irq),
      .external_irq_o   (external_irq)
    );

  always #(clk_period_c / 2) clk = ~clk;

  always #(rt_half_c) rt_clk = ~rt_clk;

  // Memory model, one command at a time, reads return address XOR a constant
  always
  begin
    @(negedge clk);
    if (!rst && mem_cmd_v && mem_cmd_ready)
    begin
      mem_last_cmd = mem_cmd_msg;
      @(posedge clk);
      #2;
      mem_cmd_ready = 1'b0;
      repeat (mem_delay[mem_count % 16] - 1)
      begin
        @(posedge clk);
        #2;
      end
      mem_count++;
      mem_resp_msg = mem_last_cmd;
      mem_resp_msg.data = (mem_last_cmd.opcode == uc_pkg::op_read)
                        ? ({32'h0, mem_last_cmd.addr} ^ mem_xor_c) : 64'h0;
      mem_resp_v = 1'b1;
      do
      begin
        @(negedge clk);
        mem_fired = mem_resp_ready;
        @(posedge clk);
        #2;
      end
      while (!mem_fired);
      mem_resp_v    = 1'b0;
      mem_cmd_ready = 1'b1;
    end
  end

  function automatic uc_pkg::uc_msg_s make_msg(input uc_pkg::uc_opcode_e op,
                                               input logic [31:0] addr,
                                               input int src,
                                               input logic [63:0] data);
    uc_pkg::uc_msg_s m;
    m.opcode = op;
    m.addr   = addr;
    m.src    = uc_pkg::src_width_gp'(src);
    m.data   = data;
    return m;
  endfunction

  task automatic check_value(input string what, input logic [127:0] got,
                             input logic [127:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      $display("ERROR %s: got 'h%0h, expected 'h%0h", what, got, exp);
      errors++;
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    checks++;
    assert (cond)
    else
    begin
      $display("%s", what);
      errors++;
    end
  endtask

  task automatic idle(input int n);
    repeat (n)
    begin
      @(posedge clk);
    end
    #2;
  endtask

  // Sample ready mid-cycle, the transfer happens on the following edge
  task automatic wait_accept(input int port);
    int  n;
    bit  took;
    n    = 0;
    took = 1'b0;
    while (!took && n < wait_limit_c)
    begin
      @(negedge clk);
      took = req_cmd_ready[port];
      n++;
      @(posedge clk);
      #2;
    end
    check_true(took, $sformatf("port %0d command was not accepted within %0d cycles",
                               port, wait_limit_c));
  endtask

  task automatic send_cmd(input int port, input uc_pkg::uc_msg_s msg);
    req_cmd_msg[port] = msg;
    req_cmd_v[port]   = 1'b1;
    wait_accept(port);
    req_cmd_v[port]   = 1'b0;
  endtask

  task automatic wait_resp(input int port, input bit check_other,
                           output uc_pkg::uc_msg_s msg, output int lat);
    bit got;
    got = 1'b0;
    lat = 0;
    msg = '0;
    while (!got && lat < wait_limit_c)
    begin
      @(negedge clk);
      lat++;
      if (req_resp_v[port])
      begin
        got = 1'b1;
        msg = req_resp_msg[port];
      end
      if (check_other)
      begin
        check_true(!req_resp_v[1-port],
                   $sformatf("port %0d saw a response meant for port %0d", 1 - port, port));
      end
      @(posedge clk);
      #2;
    end
    check_true(got, $sformatf("port %0d got no response within %0d cycles",
                              port, wait_limit_c));
  endtask

  task automatic access(input int port, input uc_pkg::uc_opcode_e op,
                        input logic [31:0] addr, input logic [63:0] wdata,
                        input bit check_other, output logic [63:0] rdata,
                        output int lat);
    uc_pkg::uc_msg_s resp;
    send_cmd(port, make_msg(op, addr, port, wdata));
    wait_resp(port, check_other, resp, lat);
    check_value($sformatf("req_resp_msg_o[%0d].src", port), resp.src, port);
    check_value($sformatf("req_resp_msg_o[%0d].addr", port), resp.addr, addr);
    check_value($sformatf("req_resp_msg_o[%0d].opcode", port), resp.opcode, op);
    rdata = resp.data;
  endtask

  task automatic finish_test(input string name, input int err0);
    tests_run++;
    if (errors == err0)
    begin
      $display("test %s passed", name);
    end
    else
    begin
      tests_failed++;
      $display("test %s failed with %0d errors", name, errors - err0);
    end
  endtask

  `include "uc_tb_tests.svh"

  initial
  begin
    void'($urandom(32'h50cd_768a));
    errors         = 0;
    checks         = 0;
    tests_run      = 0;
    tests_failed   = 0;
    mem_count      = 0;
    mem_last_cmd   = '0;
    rst            = 1'b1;
    my_did         = 8'h80 | 8'($urandom);
    req_cmd_msg    = '0;
    req_cmd_v      = 2'b00;
    req_resp_ready = 2'b11;
    mem_cmd_ready  = 1'b1;
    mem_resp_msg   = '0;
    mem_resp_v     = 1'b0;
    for (int i = 0; i < 16; i++)
    begin
      mem_delay[i] = 1 + int'($urandom % 4);
    end
    repeat (2)
    begin
      @(posedge clk);
    end
    #2;
    rst = 1'b0;

    test_cfg_regs();
    test_timer();
    test_soft_ext_irq();
    test_mem_routing();
    test_contention();

    $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0)
    begin
      $display("STATUS: PASS");
    end
    else
    begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial
  begin
    #(num_tests_c * cycles_per_test_c * clk_period_c);
    $display("watchdog expired after %0d ns, the tests did not finish",
             num_tests_c * cycles_per_test_c * clk_period_c);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// File: filelist.f
+incdir+include
rtl/uc_pkg.sv
rtl/uc_cmd_decode.sv
rtl/uc_xbar.sv
rtl/uc_cfg_slice.sv
rtl/uc_clint_slice.sv
rtl/uc_fabric.sv
verif/uc_fabric_tb.sv
